// ==== compile.f ====
rtl/ahb_sub_pkg.sv
rtl/ahb_node.sv
rtl/ahb_sram_slave.sv
rtl/ahb_timer_slave.sv
rtl/ahb_default_slave.sv
rtl/ahb_subsys_top.sv
tests/ahb_subsys_chk.sv
tests/tb_ahb_subsys.sv

// ==== rtl/ahb_default_slave.sv ====
// AHB-Lite default slave for unmapped addresses
// Two-cycle ERROR response for NONSEQ and SEQ transfers
// Zero-wait OKAY for IDLE and BUSY
module ahb_default_slave (
  input  logic                 hclk,
  input  logic                 hreset_n,
  input  logic                 hsel_i,
  input  ahb_sub_pkg::htrans_e htrans_i,
  input  logic                 hready_i,
  output logic                 hreadyout_o,
  output logic                 hresp_o
);
  import ahb_sub_pkg::*;

  typedef enum logic [1:0] {
    ERR_IDLE,
    ERR_FIRST,
    ERR_SECOND
  } err_state_e;

  err_state_e state_q;
  err_state_e state_d;
  logic       accept;

  assign accept = hsel_i && hready_i &&
                  (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

  // FIRST always moves on, SECOND may take the next transfer
  always_comb begin
    case (state_q)
      ERR_FIRST: state_d = ERR_SECOND;
      default:   state_d = accept ? ERR_FIRST : ERR_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      state_q <= ERR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ERROR in both cycles, wait only in the first
  assign hreadyout_o = (state_q != ERR_FIRST);
  assign hresp_o     = (state_q != ERR_IDLE);

endmodule

// ==== rtl/ahb_node.sv ====
// AHB-Lite address decoding node
// Range decode qualified by hsel, default slot for misses
// Address-phase broadcast to all slaves
// Registered data-phase select and response mux
module ahb_node #(
  parameter int NB_SLAVES      = 3,
  parameter int AHB_ADDR_WIDTH = ahb_sub_pkg::AHB_ADDR_WIDTH,
  parameter int AHB_DATA_WIDTH = ahb_sub_pkg::AHB_DATA_WIDTH,
  parameter logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] START_ADDR = '0,
  parameter logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] END_ADDR   = '1
) (
  input  logic                                     hclk,
  input  logic                                     hreset_n,
  // Master side
  input  logic [AHB_ADDR_WIDTH-1:0]                haddr_i,
  input  logic [AHB_DATA_WIDTH-1:0]                hwdata_i,
  input  logic                                     hsel_i,
  input  logic                                     hwrite_i,
  input  ahb_sub_pkg::htrans_e                     htrans_i,
  input  ahb_sub_pkg::hsize_e                      hsize_i,
  output logic [AHB_DATA_WIDTH-1:0]                hrdata_o,
  output logic                                     hready_o,
  output logic                                     hresp_o,
  // Slave side
  output logic [AHB_ADDR_WIDTH-1:0]                haddr_s_o,
  output logic [AHB_DATA_WIDTH-1:0]                hwdata_s_o,
  output logic [NB_SLAVES-1:0]                     hsel_s_o,
  output logic                                     hwrite_s_o,
  output ahb_sub_pkg::htrans_e                     htrans_s_o,
  output ahb_sub_pkg::hsize_e                      hsize_s_o,
  output logic                                     hready_s_o,
  input  logic [NB_SLAVES-1:0]                     hreadyout_s_i,
  input  logic [NB_SLAVES-1:0]                     hresp_s_i,
  input  logic [NB_SLAVES-1:0][AHB_DATA_WIDTH-1:0] hrdata_s_i
);
  import ahb_sub_pkg::*;

  // Per-slot range hits
  logic [NB_SLAVES-1:0] in_range;
  // Slot that owns the current data phase
  logic [NB_SLAVES-1:0] pending_sel;
  logic                 hit_any;

  // Range compare, inclusive on both ends
  always_comb begin
    for (int s = 0; s < NB_SLAVES; s++) begin
      in_range[s] = (haddr_i >= START_ADDR[s]) && (haddr_i <= END_ADDR[s]);
    end
  end

  // Lowest slot wins on overlap
  // No hit at all falls back to the last slot, the default slave
  always_comb begin
    hsel_s_o = '0;
    hit_any  = 1'b0;
    for (int s = 0; s < NB_SLAVES; s++) begin
      if (!hit_any && in_range[s]) begin
        hsel_s_o[s] = hsel_i;
        hit_any     = 1'b1;
      end
    end
    if (!hit_any) begin
      hsel_s_o[NB_SLAVES-1] = hsel_i;
    end
  end

  // Address phase goes out once, shared by all slaves
  // Deselected master looks like IDLE to every slave
  assign haddr_s_o  = haddr_i;
  assign hwrite_s_o = hsel_i && hwrite_i;
  assign htrans_s_o = hsel_i ? htrans_i : HTRANS_IDLE;
  assign hsize_s_o  = hsize_i;
  // Data-phase write data, not qualified by the address-phase hsel
  assign hwdata_s_o = hwdata_i;
  assign hready_s_o = hready_o;

  // Select moves to the data phase only when the bus advances
  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      pending_sel <= '0;
    end else if (hready_o) begin
      pending_sel <= hsel_s_o;
    end
  end

  // Response from the data-phase owner
  // Nothing pending answers ready and OKAY
  always_comb begin
    hrdata_o = '0;
    hready_o = 1'b1;
    hresp_o  = 1'b0;
    for (int s = 0; s < NB_SLAVES; s++) begin
      if (pending_sel[s]) begin
        hrdata_o = hrdata_s_i[s];
        hready_o = hreadyout_s_i[s];
        hresp_o  = hresp_s_i[s];
      end
    end
  end

endmodule

// ==== rtl/ahb_sram_slave.sv ====
// AHB-Lite SRAM slave
// Wait-state FSM with programmable number of wait cycles
// Byte-lane write merge for byte, half and word sizes
module ahb_sram_slave #(
  parameter int AHB_DATA_WIDTH = ahb_sub_pkg::AHB_DATA_WIDTH,
  parameter int DEPTH          = 256,
  parameter int WAIT_STATES    = 1
) (
  input  logic                                   hclk,
  input  logic                                   hreset_n,
  input  logic                                   hsel_i,
  input  logic [ahb_sub_pkg::AHB_ADDR_WIDTH-1:0] haddr_i,
  input  logic [AHB_DATA_WIDTH-1:0]              hwdata_i,
  input  logic                                   hwrite_i,
  input  ahb_sub_pkg::htrans_e                   htrans_i,
  input  ahb_sub_pkg::hsize_e                    hsize_i,
  input  logic                                   hready_i,
  output logic                                   hreadyout_o,
  output logic                                   hresp_o,
  output logic [AHB_DATA_WIDTH-1:0]              hrdata_o
);
  import ahb_sub_pkg::*;

  localparam int NB_LANES  = AHB_DATA_WIDTH / 8;
  localparam int LANE_BITS = $clog2(NB_LANES);
  localparam int IDX_W     = $clog2(DEPTH);
  // Counter is at least one bit wide even without wait states
  localparam int WCNT_W    = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

  typedef enum logic [1:0] {
    SRAM_IDLE,
    SRAM_WAIT,
    SRAM_DATA
  } sram_state_e;

  sram_state_e state_q;
  sram_state_e state_d;
  logic [WCNT_W-1:0] wait_cnt_q;
  logic accept;
  logic commit;
  logic [LANE_BITS-1:0] lane_idx;
  logic [NB_LANES-1:0] lane_mask;
  // Captured address phase
  logic [IDX_W-1:0] word_q;
  logic write_q;
  logic [NB_LANES-1:0] mask_q;
  logic [AHB_DATA_WIDTH-1:0] mem [DEPTH];

  // Active transfer seen while the bus advances
  assign accept = hsel_i && hready_i &&
                  (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

  // Lanes touched by this size and address
  assign lane_idx = haddr_i[LANE_BITS-1:0];
  always_comb begin
    case (hsize_i)
      HSIZE_BYTE: lane_mask = NB_LANES'(1) << lane_idx;
      HSIZE_HALF: lane_mask = NB_LANES'(2'b11) << (lane_idx & ~(LANE_BITS'(1)));
      HSIZE_WORD: lane_mask = NB_LANES'(4'hF) << (lane_idx & ~(LANE_BITS'(3)));
      default:    lane_mask = '1;
    endcase
  end

  // Next state
  // DATA is the last cycle and may overlap a new address phase
  always_comb begin
    state_d = state_q;
    case (state_q)
      SRAM_WAIT: begin
        if (wait_cnt_q == WCNT_W'(WAIT_STATES - 1)) begin
          state_d = SRAM_DATA;
        end
      end
      default: begin
        if (accept) begin
          state_d = (WAIT_STATES > 0) ? SRAM_WAIT : SRAM_DATA;
        end else begin
          state_d = SRAM_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      state_q    <= SRAM_IDLE;
      wait_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      // Counts only inside the wait window
      if (state_q == SRAM_WAIT) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end else begin
        wait_cnt_q <= '0;
      end
    end
  end

  // Address-phase capture
  always_ff @(posedge hclk) begin
    if (accept) begin
      word_q  <= haddr_i[LANE_BITS +: IDX_W];
      write_q <= hwrite_i;
      mask_q  <= lane_mask;
    end
  end

  // Write lands on the final data-phase edge, lane by lane
  assign commit = (state_q == SRAM_DATA) && write_q;
  always_ff @(posedge hclk) begin
    if (commit) begin
      for (int b = 0; b < NB_LANES; b++) begin
        if (mask_q[b]) begin
          mem[word_q][8*b +: 8] <= hwdata_i[8*b +: 8];
        end
      end
    end
  end

  assign hrdata_o    = mem[word_q];
  assign hreadyout_o = (state_q != SRAM_WAIT);
  assign hresp_o     = 1'b0;

endmodule

// ==== rtl/ahb_sub_pkg.sv ====
// Shared definitions for the AHB-Lite memory subsystem
// Bus widths, transfer type and size encodings
// Slave address map and timer register offsets
package ahb_sub_pkg;

  // Bus widths, defaults for every module parameter
  localparam int AHB_ADDR_WIDTH = 32;
  localparam int AHB_DATA_WIDTH = 32;

  // AHB transfer type, HTRANS[1:0]
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // Transfer size, HSIZE[2:0]
  // Only byte, half and word sizes are used on this bus
  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_e;

  // SRAM window, 1 KB
  localparam logic [31:0] SRAM_BASE  = 32'h0000_0000;
  localparam logic [31:0] SRAM_LAST  = 32'h0000_03FF;

  // Timer window, four word registers
  localparam logic [31:0] TIMER_BASE = 32'h0001_0000;
  localparam logic [31:0] TIMER_LAST = 32'h0001_000F;

  // Timer register word offsets, taken from haddr[3:2]
  typedef enum logic [1:0] {
    TREG_CTRL    = 2'd0,
    TREG_COUNT   = 2'd1,
    TREG_COMPARE = 2'd2,
    TREG_STATUS  = 2'd3
  } timer_reg_e;

  // Anything outside both windows goes to the default slave
  // and gets an ERROR response

endpackage

// ==== rtl/ahb_subsys_top.sv ====
// AHB-Lite memory subsystem top level
// Address node with SRAM, timer and default slaves
// Node address map built from the package
module ahb_subsys_top #(
  parameter int AHB_ADDR_WIDTH   = ahb_sub_pkg::AHB_ADDR_WIDTH,
  parameter int AHB_DATA_WIDTH   = ahb_sub_pkg::AHB_DATA_WIDTH,
  parameter int SRAM_DEPTH       = 256,
  parameter int SRAM_WAIT_STATES = 1,
  parameter int TIMER_PRESCALE   = 4
) (
  input  logic                      hclk,
  input  logic                      hreset_n,
  input  logic [AHB_ADDR_WIDTH-1:0] haddr_i,
  input  logic [AHB_DATA_WIDTH-1:0] hwdata_i,
  input  logic                      hsel_i,
  input  logic                      hwrite_i,
  input  ahb_sub_pkg::htrans_e      htrans_i,
  input  ahb_sub_pkg::hsize_e       hsize_i,
  output logic [AHB_DATA_WIDTH-1:0] hrdata_o,
  output logic                      hready_o,
  output logic                      hresp_o,
  output logic                      irq_o
);
  import ahb_sub_pkg::*;

  // Slot order on the node, default slave last
  localparam int NB_SLAVES = 3;
  localparam int SLV_SRAM  = 0;
  localparam int SLV_TIMER = 1;
  localparam int SLV_DEF   = 2;

  // Default slot spans the whole map and only catches misses
  localparam logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] NODE_START = {
    {AHB_ADDR_WIDTH{1'b0}}, AHB_ADDR_WIDTH'(TIMER_BASE), AHB_ADDR_WIDTH'(SRAM_BASE)};
  localparam logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] NODE_END = {
    {AHB_ADDR_WIDTH{1'b1}}, AHB_ADDR_WIDTH'(TIMER_LAST), AHB_ADDR_WIDTH'(SRAM_LAST)};

  // Slave-side bus
  logic [AHB_ADDR_WIDTH-1:0]                haddr_s;
  logic [AHB_DATA_WIDTH-1:0]                hwdata_s;
  logic [NB_SLAVES-1:0]                     hsel_s;
  logic                                     hwrite_s;
  htrans_e                                  htrans_s;
  hsize_e                                   hsize_s;
  logic                                     hready_s;
  logic [NB_SLAVES-1:0]                     hreadyout_s;
  logic [NB_SLAVES-1:0]                     hresp_s;
  logic [NB_SLAVES-1:0][AHB_DATA_WIDTH-1:0] hrdata_s;

  ahb_node #(
    .NB_SLAVES      (NB_SLAVES),
    .AHB_ADDR_WIDTH (AHB_ADDR_WIDTH),
    .AHB_DATA_WIDTH (AHB_DATA_WIDTH),
    .START_ADDR     (NODE_START),
    .END_ADDR       (NODE_END)
  ) u_node (
    .hclk          (hclk),
    .hreset_n      (hreset_n),
    .haddr_i       (haddr_i),
    .hwdata_i      (hwdata_i),
    .hsel_i        (hsel_i),
    .hwrite_i      (hwrite_i),
    .htrans_i      (htrans_i),
    .hsize_i       (hsize_i),
    .hrdata_o      (hrdata_o),
    .hready_o      (hready_o),
    .hresp_o       (hresp_o),
    .haddr_s_o     (haddr_s),
    .hwdata_s_o    (hwdata_s),
    .hsel_s_o      (hsel_s),
    .hwrite_s_o    (hwrite_s),
    .htrans_s_o    (htrans_s),
    .hsize_s_o     (hsize_s),
    .hready_s_o    (hready_s),
    .hreadyout_s_i (hreadyout_s),
    .hresp_s_i     (hresp_s),
    .hrdata_s_i    (hrdata_s)
  );

  ahb_sram_slave #(
    .AHB_DATA_WIDTH (AHB_DATA_WIDTH),
    .DEPTH          (SRAM_DEPTH),
    .WAIT_STATES    (SRAM_WAIT_STATES)
  ) u_sram (
    .hclk        (hclk),
    .hreset_n    (hreset_n),
    .hsel_i      (hsel_s[SLV_SRAM]),
    .haddr_i     (haddr_s),
    .hwdata_i    (hwdata_s),
    .hwrite_i    (hwrite_s),
    .htrans_i    (htrans_s),
    .hsize_i     (hsize_s),
    .hready_i    (hready_s),
    .hreadyout_o (hreadyout_s[SLV_SRAM]),
    .hresp_o     (hresp_s[SLV_SRAM]),
    .hrdata_o    (hrdata_s[SLV_SRAM])
  );

  ahb_timer_slave #(
    .AHB_DATA_WIDTH (AHB_DATA_WIDTH),
    .PRESCALE       (TIMER_PRESCALE)
  ) u_timer (
    .hclk        (hclk),
    .hreset_n    (hreset_n),
    .hsel_i      (hsel_s[SLV_TIMER]),
    .haddr_i     (haddr_s),
    .hwdata_i    (hwdata_s),
    .hwrite_i    (hwrite_s),
    .htrans_i    (htrans_s),
    .hready_i    (hready_s),
    .hreadyout_o (hreadyout_s[SLV_TIMER]),
    .hresp_o     (hresp_s[SLV_TIMER]),
    .hrdata_o    (hrdata_s[SLV_TIMER]),
    .irq_o       (irq_o)
  );

  ahb_default_slave u_default (
    .hclk        (hclk),
    .hreset_n    (hreset_n),
    .hsel_i      (hsel_s[SLV_DEF]),
    .htrans_i    (htrans_s),
    .hready_i    (hready_s),
    .hreadyout_o (hreadyout_s[SLV_DEF]),
    .hresp_o     (hresp_s[SLV_DEF])
  );

  // Default slave returns no data
  assign hrdata_s[SLV_DEF] = '0;

endmodule

// ==== rtl/ahb_timer_slave.sv ====
// AHB-Lite timer slave
// Prescaled counter with compare register
// Sticky match status, write 1 to clear, and interrupt
module ahb_timer_slave #(
  parameter int AHB_DATA_WIDTH = ahb_sub_pkg::AHB_DATA_WIDTH,
  parameter int PRESCALE       = 4
) (
  input  logic                                   hclk,
  input  logic                                   hreset_n,
  input  logic                                   hsel_i,
  input  logic [ahb_sub_pkg::AHB_ADDR_WIDTH-1:0] haddr_i,
  input  logic [AHB_DATA_WIDTH-1:0]              hwdata_i,
  input  logic                                   hwrite_i,
  input  ahb_sub_pkg::htrans_e                   htrans_i,
  input  logic                                   hready_i,
  output logic                                   hreadyout_o,
  output logic                                   hresp_o,
  output logic [AHB_DATA_WIDTH-1:0]              hrdata_o,
  output logic                                   irq_o
);
  import ahb_sub_pkg::*;

  localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

  logic accept;
  // Data-phase view of the accepted transfer
  logic dp_valid_q;
  logic dp_write_q;
  timer_reg_e dp_reg_q;
  logic bus_wr;
  // CTRL bit 0 enable, bit 1 interrupt enable
  logic [1:0] ctrl_q;
  logic [AHB_DATA_WIDTH-1:0] count_q;
  logic [AHB_DATA_WIDTH-1:0] compare_q;
  logic match_q;
  logic match_clr;
  logic [PRE_W-1:0] pre_cnt_q;
  logic tick;
  logic hit;

  assign accept = hsel_i && hready_i &&
                  (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      dp_valid_q <= 1'b0;
      dp_write_q <= 1'b0;
      dp_reg_q   <= TREG_CTRL;
    end else if (hready_i) begin
      dp_valid_q <= accept;
      dp_write_q <= hwrite_i;
      dp_reg_q   <= timer_reg_e'(haddr_i[3:2]);
    end
  end

  // Zero wait, so the data phase ends on the next edge
  assign bus_wr = dp_valid_q && dp_write_q && hready_i;

  // Prescaler, held at zero while disabled
  assign tick = ctrl_q[0] && (pre_cnt_q == PRE_W'(PRESCALE - 1));
  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      pre_cnt_q <= '0;
    end else if (!ctrl_q[0] || tick) begin
      pre_cnt_q <= '0;
    end else begin
      pre_cnt_q <= pre_cnt_q + 1'b1;
    end
  end

  // Match seen at a step, counter wraps on that step
  assign hit       = tick && (count_q == compare_q);
  assign match_clr = bus_wr && (dp_reg_q == TREG_STATUS) && hwdata_i[0];

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      ctrl_q    <= '0;
      count_q   <= '0;
      compare_q <= '0;
      match_q   <= 1'b0;
    end else begin
      if (tick) begin
        count_q <= hit ? '0 : count_q + 1'b1;
      end
      // New match wins over a clear in the same cycle
      match_q <= hit || (match_q && !match_clr);
      // Bus write overrides the counter step
      if (bus_wr) begin
        case (dp_reg_q)
          TREG_CTRL:    ctrl_q    <= hwdata_i[1:0];
          TREG_COUNT:   count_q   <= hwdata_i;
          TREG_COMPARE: compare_q <= hwdata_i;
          default:      ;
        endcase
      end
    end
  end

  // Read data during the data phase
  always_comb begin
    hrdata_o = '0;
    if (dp_valid_q && !dp_write_q) begin
      case (dp_reg_q)
        TREG_CTRL:    hrdata_o = AHB_DATA_WIDTH'(ctrl_q);
        TREG_COUNT:   hrdata_o = count_q;
        TREG_COMPARE: hrdata_o = compare_q;
        TREG_STATUS:  hrdata_o = AHB_DATA_WIDTH'(match_q);
        default:      hrdata_o = '0;
      endcase
    end
  end

  assign hreadyout_o = 1'b1;
  assign hresp_o     = 1'b0;
  assign irq_o       = match_q && ctrl_q[1];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the AHB-Lite subsystem testbench with Verilator and runs it
# The run passes only if the testbench prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_ahb_subsys \
  -f compile.f -o sim_tb &&
out="$(./obj_dir/sim_tb +verilator+error+limit+100)" ;
echo "$out" ;
echo "$out" | grep -qx "All tests passed" &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }

// ==== tests/ahb_subsys_chk.sv ====
// Protocol assertions for the AHB-Lite address node
// One-hot select, two-cycle ERROR shape, ready out of reset
module ahb_subsys_chk #(
  parameter int NB_SLAVES = 3
) (
  input logic                 hclk,
  input logic                 hreset_n,
  input logic [NB_SLAVES-1:0] hsel_s_i,
  input logic [NB_SLAVES-1:0] pending_sel_i,
  input logic                 hready_i,
  input logic                 hresp_i
);
  // Assertion failures seen so far
  int n_fail = 0;

  // At most one slave in the address phase and one in the data phase
  sel_onehot: assert property (@(posedge hclk) disable iff (!hreset_n)
    $onehot0(hsel_s_i) && $onehot0(pending_sel_i))
    else begin
      n_fail++;
      $error("more than one slave select active");
    end

  // First ERROR cycle waits, second one completes
  err_two_cycle: assert property (@(posedge hclk) disable iff (!hreset_n)
    (hresp_i && !hready_i) |=> (hresp_i && hready_i))
    else begin
      n_fail++;
      $error("ERROR response not followed by its completing cycle");
    end

  // Nothing pending right after reset
  ready_out_of_reset: assert property (@(posedge hclk) $rose(hreset_n) |-> hready_i)
    else begin
      n_fail++;
      $error("hready_o low right after reset");
    end

endmodule

// Attach to every node instance
bind ahb_node ahb_subsys_chk #(.NB_SLAVES(NB_SLAVES)) chk0 (
  .hclk          (hclk),
  .hreset_n      (hreset_n),
  .hsel_s_i      (hsel_s_o),
  .pending_sel_i (pending_sel),
  .hready_i      (hready_o),
  .hresp_i       (hresp_o)
);

// ==== tests/tb_ahb_subsys.sv ====
// Testbench for the AHB-Lite memory subsystem
// Clock, reset, LFSR data source and AHB master tasks
// Directed tests for SRAM, timer, default slave and pipelining
module tb_ahb_subsys;
  import ahb_sub_pkg::*;

  localparam int SRAM_DEPTH    = 256;
  localparam int SRAM_WAITS    = 1;
  localparam int PRESCALE      = 4;
  localparam int READY_TIMEOUT = 50;
  localparam int POLL_LIMIT    = 100;
  localparam logic [31:0] UNMAPPED = 32'h0002_0000;

  logic        hclk;
  logic        hreset_n;
  logic [31:0] haddr;
  logic [31:0] hwdata;
  logic        hsel;
  logic        hwrite;
  htrans_e     htrans;
  hsize_e      hsize;
  logic [31:0] hrdata;
  logic        hready;
  logic        hresp;
  logic        irq;

  // Transfer slots filled before each burst of issues
  logic        p_write [4];
  logic [31:0] p_addr  [4];
  hsize_e      p_size  [4];
  logic [31:0] p_wdata [4];
  // Per-slot results
  // Response at completion and response seen during wait cycles
  logic [31:0] p_rdata [4];
  logic        p_resp  [4];
  int          p_waits [4];
  logic        p_wresp [4];

  logic [31:0] lfsr_q;
  logic [31:0] merged_word;
  logic [31:0] count_val;
  int          n_checks;
  int          n_errors;

  ahb_subsys_top #(
    .SRAM_DEPTH       (SRAM_DEPTH),
    .SRAM_WAIT_STATES (SRAM_WAITS),
    .TIMER_PRESCALE   (PRESCALE)
  ) dut0 (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .haddr_i  (haddr),
    .hwdata_i (hwdata),
    .hsel_i   (hsel),
    .hwrite_i (hwrite),
    .htrans_i (htrans),
    .hsize_i  (hsize),
    .hrdata_o (hrdata),
    .hready_o (hready),
    .hresp_o  (hresp),
    .irq_o    (irq)
  );

  initial begin
    hclk = 1'b0;
    forever #10 hclk = ~hclk;
  end

  // Fibonacci LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  // One step per bit taken
  function automatic logic [31:0] random_word(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic logic [31:0] timer_addr(input timer_reg_e r);
    return TIMER_BASE + {28'd0, r, 2'b00};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("ERROR t=%0t %s: expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_resp(input int slot, input string name, input logic resp,
                            input int waits);
    check_value({name, " hresp_o"}, resp, p_resp[slot]);
    check_value({name, " wait cycles"}, waits, p_waits[slot]);
  endtask

  task automatic finish_run();
    $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
             n_checks, n_errors, dut0.u_node.chk0.n_fail);
    if (n_errors + dut0.u_node.chk0.n_fail == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic set_slot(input int slot, input logic write, input logic [31:0] addr,
                          input hsize_e size, input logic [31:0] data);
    p_write[slot] = write;
    p_addr[slot]  = addr;
    p_size[slot]  = size;
    p_wdata[slot] = data;
  endtask

  task automatic drive_addr(input int slot);
    haddr  <= p_addr[slot];
    hsel   <= 1'b1;
    htrans <= HTRANS_NONSEQ;
    hwrite <= p_write[slot];
    hsize  <= p_size[slot];
  endtask

  task automatic drive_idle();
    hsel   <= 1'b0;
    htrans <= HTRANS_IDLE;
    hwrite <= 1'b0;
  endtask

  // Issue n slots back to back
  // Next address overlaps the current data phase
  task automatic ahb_pipe(input int n);
    int  on_bus;
    int  dp;
    int  stall;
    bit  done;
    on_bus = 0;
    dp     = -1;
    stall  = 0;
    done   = 1'b0;
    for (int i = 0; i < n; i++) begin
      p_waits[i] = 0;
      p_wresp[i] = 1'b0;
    end
    @(posedge hclk);
    drive_addr(0);
    while (!done) begin
      // Sample mid-cycle where the responses are settled
      @(negedge hclk);
      if (hready) begin
        stall = 0;
        if (dp >= 0) begin
          p_rdata[dp] = hrdata;
          p_resp[dp]  = hresp;
        end
        @(posedge hclk);
        // Address on the bus was taken at this edge
        dp = (on_bus < n) ? on_bus : -1;
        if (dp >= 0 && p_write[dp]) begin
          hwdata <= p_wdata[dp];
        end
        if (on_bus < n) begin
          on_bus++;
        end
        if (on_bus < n) begin
          drive_addr(on_bus);
        end else begin
          drive_idle();
        end
        done = (dp < 0);
      end else begin
        stall++;
        if (dp >= 0) begin
          p_waits[dp]++;
          p_wresp[dp] = p_wresp[dp] | hresp;
        end
        if (stall > READY_TIMEOUT) begin
          n_errors++;
          $display("Timeout: hready_o stayed low for %0d cycles", stall);
          done = 1'b1;
        end
      end
    end
  endtask

  task automatic ahb_write(input logic [31:0] addr, input hsize_e size,
                           input logic [31:0] data);
    set_slot(0, 1'b1, addr, size, data);
    ahb_pipe(1);
  endtask

  task automatic ahb_read(input logic [31:0] addr, input hsize_e size);
    set_slot(0, 1'b0, addr, size, '0);
    ahb_pipe(1);
  endtask

  task automatic test_reset();
    @(negedge hclk);
    check_value("hready_o after reset", 1'b1, hready);
    check_value("hresp_o after reset", 1'b0, hresp);
    check_value("irq_o after reset", 1'b0, irq);
  endtask

  task automatic test_sram_words();
    logic [31:0] words [8];
    for (int i = 0; i < 8; i++) begin
      words[i] = random_word(32);
      ahb_write(SRAM_BASE + 32'(i) * 32'h84, HSIZE_WORD, words[i]);
      check_resp(0, "sram write", 1'b0, SRAM_WAITS);
    end
    for (int i = 0; i < 8; i++) begin
      ahb_read(SRAM_BASE + 32'(i) * 32'h84, HSIZE_WORD);
      check_resp(0, "sram read", 1'b0, SRAM_WAITS);
      check_value("sram hrdata_o", words[i], p_rdata[0]);
    end
  endtask

  // Word write followed by a lane 2 byte and a low half
  task automatic test_byte_lanes();
    logic [31:0] w;
    logic [31:0] b;
    logic [31:0] h;
    w = random_word(32);
    b = random_word(32);
    h = random_word(32);
    ahb_write(SRAM_BASE + 32'h100, HSIZE_WORD, w);
    ahb_write(SRAM_BASE + 32'h102, HSIZE_BYTE, b);
    ahb_write(SRAM_BASE + 32'h100, HSIZE_HALF, h);
    merged_word = {w[31:24], b[23:16], h[15:0]};
    ahb_read(SRAM_BASE + 32'h100, HSIZE_WORD);
    check_resp(0, "lane read", 1'b0, SRAM_WAITS);
    check_value("lane merge hrdata_o", merged_word, p_rdata[0]);
  endtask

  task automatic test_timer();
    int polls;
    ahb_write(timer_addr(TREG_COMPARE), HSIZE_WORD, 32'd5);
    check_resp(0, "timer write", 1'b0, 0);
    // Enable plus interrupt enable
    ahb_write(timer_addr(TREG_CTRL), HSIZE_WORD, 32'h3);
    polls = 0;
    do begin
      ahb_read(timer_addr(TREG_STATUS), HSIZE_WORD);
      polls++;
    end while (p_rdata[0][0] !== 1'b1 && polls < POLL_LIMIT);
    if (p_rdata[0][0] !== 1'b1) begin
      n_errors++;
      $display("Timer match status did not set within %0d polls", polls);
    end
    @(negedge hclk);
    check_value("irq_o on match", 1'b1, irq);
    ahb_write(timer_addr(TREG_STATUS), HSIZE_WORD, 32'h1);
    ahb_read(timer_addr(TREG_STATUS), HSIZE_WORD);
    check_value("timer status after clear", 32'h0, p_rdata[0]);
    @(negedge hclk);
    check_value("irq_o after clear", 1'b0, irq);
    // Stopped counter keeps a written value
    ahb_write(timer_addr(TREG_CTRL), HSIZE_WORD, 32'h0);
    count_val = random_word(32);
    ahb_write(timer_addr(TREG_COUNT), HSIZE_WORD, count_val);
    ahb_read(timer_addr(TREG_COUNT), HSIZE_WORD);
    check_resp(0, "timer read", 1'b0, 0);
    check_value("timer count hrdata_o", count_val, p_rdata[0]);
  endtask

  task automatic test_unmapped();
    ahb_read(UNMAPPED, HSIZE_WORD);
    check_resp(0, "unmapped read", 1'b1, 1);
    check_value("unmapped first cycle hresp_o", 1'b1, p_wresp[0]);
    ahb_read(SRAM_BASE + 32'h100, HSIZE_WORD);
    check_resp(0, "sram read after error", 1'b0, SRAM_WAITS);
    check_value("sram hrdata_o after error", merged_word, p_rdata[0]);
  endtask

  task automatic test_pipeline();
    logic [31:0] data;
    data = random_word(32);
    set_slot(0, 1'b1, SRAM_BASE + 32'h200, HSIZE_WORD, data);
    set_slot(1, 1'b0, timer_addr(TREG_COUNT), HSIZE_WORD, '0);
    set_slot(2, 1'b0, SRAM_BASE + 32'h200, HSIZE_WORD, '0);
    set_slot(3, 1'b0, UNMAPPED + 32'h40, HSIZE_WORD, '0);
    ahb_pipe(4);
    check_resp(0, "pipe sram write", 1'b0, SRAM_WAITS);
    check_resp(1, "pipe timer read", 1'b0, 0);
    check_value("pipe timer hrdata_o", count_val, p_rdata[1]);
    check_resp(2, "pipe sram read", 1'b0, SRAM_WAITS);
    check_value("pipe sram hrdata_o", data, p_rdata[2]);
    check_resp(3, "pipe unmapped read", 1'b1, 1);
  endtask

  initial begin
    lfsr_q      = 32'd98493;
    merged_word = '0;
    count_val   = '0;
    n_checks    = 0;
    n_errors    = 0;
    hreset_n    = 1'b0;
    haddr       = '0;
    hwdata      = '0;
    hsel        = 1'b0;
    hwrite      = 1'b0;
    htrans      = HTRANS_IDLE;
    hsize       = HSIZE_WORD;
    repeat (16) @(posedge hclk);
    hreset_n <= 1'b1;
    test_reset();
    test_sram_words();
    test_byte_lanes();
    test_timer();
    test_unmapped();
    test_pipeline();
    finish_run();
  end

endmodule
